/* src/dbg_pkg.sv */
// Shared types and data register layout of the OR1K debug module
// Only 32-bit bursts are decoded and the status register is the one internal register
package dbg_pkg;

  ////////////////////
  // Data register layout
  localparam int DR_W       = 53;
  localparam int DR_TOP_BIT = 52;  // 0 means the command is for this module
  localparam int OP_MSB     = 51;
  localparam int OP_LSB     = 48;
  localparam int OP_RD_BIT  = 2;   // Set in read opcodes
  localparam int ADDR_MSB   = 47;
  localparam int ADDR_LSB   = 16;
  localparam int CNT_LSB    = 0;   // Word count, width set by the top level

  // Internal register select, one register for now
  localparam int REGSEL_W      = 1;
  localparam int INTREG_STATUS = 0;
  localparam int STAT_MSB      = ADDR_MSB - REGSEL_W;  // Status write data sits below select

  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;  // Reflected CRC-32

  typedef enum logic [3:0] {
    CMD_BWRITE32 = 4'd3,
    CMD_BREAD32  = 4'd7,
    CMD_IREG_WR  = 4'd9,
    CMD_IREG_SEL = 4'd13
  } dbg_cmd_e;

  typedef enum logic [3:0] {
    S_IDLE, S_RBEGIN, S_RREADY, S_RSTATUS, S_RBURST, S_RCRC,
    S_WREADY, S_WWAIT, S_WBURST, S_WCRC, S_WMATCH
  } dbg_state_e;

  typedef enum logic [1:0] {
    TDO_READY = 2'd0,  // Bus unit ready bit
    TDO_DATA  = 2'd1,  // Output shift register LSB
    TDO_MATCH = 2'd2,
    TDO_CRC   = 2'd3
  } tdo_sel_e;

  ////////////////////
  // Bundles between units
  typedef struct packed {
    logic capture;
    logic shift;
    logic update;
    logic sel;     // This module selected at the TAP
  } tap_ctrl_t;

  typedef struct packed {
    logic     addr_ld;
    logic     addr_inc;
    logic     op_ld;
    logic     bit_en;
    logic     bit_clr;    // Wins over bit_en
    logic     word_ld;
    logic     word_dec;
    logic     out_ld;     // Wins over out_shift
    logic     out_shift;
    logic     out_src;    // 0 bus data, 1 internal register
    logic     regsel_ld;
    logic     intreg_we;
    tdo_sel_e tdo_sel;
  } dbg_ctrl_t;

  typedef struct packed {
    logic word_zero;
    logic word_next_zero;
    logic bit_max;         // 31 bits counted
    logic bit_32;
  } dbg_flags_t;

  typedef struct packed {
    logic clr;
    logic en;
    logic in_sel;  // 0 read data, 1 tdi
    logic shift;
  } crc_ctrl_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        stb;
    logic        we;
  } spr_req_t;

endpackage

/* src/dbg_cmd_fsm.sv */
// Burst control FSM, high-speed mode only, one clock domain on tck
// Assumes the TAP shifts without pauses once a burst has been captured
module dbg_cmd_fsm import dbg_pkg::*; (
  input  logic       tck_i,
  input  logic       rst_i,
  input  tap_ctrl_t  tap_i,
  input  dbg_cmd_e   opcode_i,        // Straight from the data register, not latched
  input  logic       cmd_for_me_i,
  input  logic       start_bit_i,
  input  dbg_flags_t flags_i,
  input  logic       biu_ready_i,
  output dbg_ctrl_t  ctrl_o,
  output crc_ctrl_t  crc_o,
  output logic       biu_strobe_o,
  output logic       top_inhibit_o
);

  dbg_state_e state_q, state_n;
  logic       cmd_hit;     // Update of a command aimed at this module
  logic       burst_cmd;
  logic       intreg_cmd;

  assign cmd_hit    = tap_i.sel & tap_i.update & cmd_for_me_i;
  assign burst_cmd  = (opcode_i == CMD_BWRITE32) | (opcode_i == CMD_BREAD32);
  assign intreg_cmd = (opcode_i == CMD_IREG_WR) | (opcode_i == CMD_IREG_SEL);

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////
  // Next state
  always_comb begin
    state_n = state_q;
    case (state_q)
      S_IDLE: begin
        if (cmd_hit && burst_cmd) begin
          state_n = (opcode_i == CMD_BREAD32) ? S_RBEGIN : S_WREADY;
        end
      end
      S_RBEGIN:  state_n = flags_i.word_zero ? S_IDLE : S_RREADY;  // Zero count is illegal
      S_RREADY: begin
        if (tap_i.update) state_n = S_IDLE;
        else if (tap_i.sel && tap_i.capture) state_n = S_RSTATUS;
      end
      S_RSTATUS: begin
        if (tap_i.update) state_n = S_IDLE;
        else if (biu_ready_i) state_n = S_RBURST;  // First 1 on TDO
      end
      S_RBURST: begin
        if (tap_i.update) begin
          state_n = S_IDLE;
        end else if (flags_i.bit_max) begin
          if (flags_i.word_zero) state_n = S_RCRC;
          else if (!biu_ready_i) state_n = S_IDLE;  // Bus too slow, abort burst
        end
      end
      S_RCRC:    if (tap_i.update) state_n = S_IDLE;  // Also the recovery state
      S_WREADY: begin
        if (flags_i.word_zero || tap_i.update) state_n = S_IDLE;
        else if (tap_i.sel && tap_i.capture) state_n = S_WWAIT;
      end
      S_WWAIT: begin
        if (tap_i.update) state_n = S_IDLE;
        else if (tap_i.sel && start_bit_i) state_n = S_WBURST;
      end
      S_WBURST: begin
        if (tap_i.update) state_n = S_IDLE;
        else if (flags_i.bit_max && flags_i.word_zero) state_n = S_WCRC;
      end
      S_WCRC: begin
        if (tap_i.update) state_n = S_IDLE;
        else if (flags_i.bit_32) state_n = S_WMATCH;
      end
      S_WMATCH:  if (tap_i.update) state_n = S_IDLE;
      default:   state_n = S_IDLE;
    endcase
  end

  ////////////////////
  // Outputs
  always_comb begin
    ctrl_o         = '0;
    ctrl_o.tdo_sel = TDO_DATA;
    crc_o          = '0;
    biu_strobe_o   = 1'b0;
    top_inhibit_o  = 1'b0;
    case (state_q)
      S_IDLE: begin
        // Internal register access stays in idle
        ctrl_o.out_shift = tap_i.sel & tap_i.shift;
        if (tap_i.sel && tap_i.capture) begin
          ctrl_o.out_ld  = 1'b1;
          ctrl_o.out_src = 1'b1;
        end
        ctrl_o.regsel_ld = cmd_hit & intreg_cmd;
        ctrl_o.intreg_we = cmd_hit & (opcode_i == CMD_IREG_WR);
        if (state_n != S_IDLE) begin  // Same setup for read and write
          ctrl_o.addr_ld = 1'b1;
          ctrl_o.op_ld   = 1'b1;
          ctrl_o.bit_clr = 1'b1;
          ctrl_o.word_ld = 1'b1;
          crc_o.clr      = 1'b1;
        end
      end
      S_RBEGIN: begin
        if (!flags_i.word_zero) begin  // Fetch word 0 early
          biu_strobe_o    = 1'b1;
          ctrl_o.addr_inc = 1'b1;
        end
      end
      S_RSTATUS: begin
        ctrl_o.tdo_sel = TDO_READY;
        top_inhibit_o  = 1'b1;
        if (state_n == S_RBURST) begin
          ctrl_o.out_ld   = 1'b1;
          ctrl_o.bit_clr  = 1'b1;
          ctrl_o.word_dec = 1'b1;
          if (!flags_i.word_next_zero) begin  // Prefetch the next word
            biu_strobe_o    = 1'b1;
            ctrl_o.addr_inc = 1'b1;
          end
        end
      end
      S_RBURST: begin
        ctrl_o.out_shift = 1'b1;
        ctrl_o.bit_en    = 1'b1;
        crc_o.en         = 1'b1;  // CRC over the bit now on TDO
        top_inhibit_o    = 1'b1;
        if (flags_i.bit_max && state_n == S_RBURST) begin
          ctrl_o.out_ld   = 1'b1;
          ctrl_o.bit_clr  = 1'b1;
          ctrl_o.word_dec = 1'b1;
          if (!flags_i.word_next_zero) begin
            biu_strobe_o    = 1'b1;
            ctrl_o.addr_inc = 1'b1;
          end
        end
      end
      S_RCRC: begin
        ctrl_o.tdo_sel = TDO_CRC;
        crc_o.shift    = 1'b1;
        top_inhibit_o  = 1'b1;
      end
      S_WWAIT: begin
        top_inhibit_o = 1'b1;
        if (state_n == S_WBURST) begin
          // tdi already holds data bit 0 when the start bit reaches bit 52
          ctrl_o.bit_en   = 1'b1;
          ctrl_o.word_dec = 1'b1;
          crc_o.en        = 1'b1;
          crc_o.in_sel    = 1'b1;
        end
      end
      S_WBURST: begin
        ctrl_o.bit_en = 1'b1;
        crc_o.en      = 1'b1;
        crc_o.in_sel  = 1'b1;
        top_inhibit_o = 1'b1;
        if (flags_i.bit_max && state_n != S_IDLE) begin  // Full word in tdi and DR
          ctrl_o.bit_clr  = 1'b1;
          ctrl_o.addr_inc = 1'b1;
          ctrl_o.word_dec = ~flags_i.word_zero;
          biu_strobe_o    = 1'b1;
        end
      end
      S_WCRC: begin
        ctrl_o.bit_en = 1'b1;
        top_inhibit_o = 1'b1;
        if (state_n == S_WMATCH) ctrl_o.tdo_sel = TDO_MATCH;
      end
      S_WMATCH: begin
        ctrl_o.tdo_sel = TDO_MATCH;
        top_inhibit_o  = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

/* src/dbg_burst_datapath.sv */
// Counters, register select and output shift path of the debug module
// Word count field width is COUNT_W, addresses advance by one word
module dbg_burst_datapath import dbg_pkg::*; #(
  parameter int COUNT_W = 16
) (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic [DR_W-1:0] data_register_i,
  input  dbg_ctrl_t       ctrl_i,
  input  logic [31:0]     biu_rdata_i,
  input  logic [1:0]      status_i,
  input  logic            biu_ready_i,
  input  logic            crc_match_i,
  input  logic            crc_serial_i,
  output dbg_flags_t      flags_o,
  output logic [31:0]     addr_o,
  output logic            rd_o,
  output logic            status_we_o,
  output logic            shift_lsb_o,
  output logic            tdo_o
);

  logic [31:0]         addr_q;
  logic [3:0]          op_q;
  logic [5:0]          bit_q;
  logic [COUNT_W-1:0]  word_q;
  logic [REGSEL_W-1:0] regsel_q;
  logic [REGSEL_W-1:0] regsel_in;
  logic [31:0]         intreg_data;
  logic [31:0]         out_q;

  assign regsel_in = data_register_i[ADDR_MSB -: REGSEL_W];

  ////////////////////
  // Address, opcode, bit and word counters
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q <= '0;
      op_q   <= '0;
      bit_q  <= '0;
      word_q <= '0;
    end else begin
      if (ctrl_i.addr_ld) addr_q <= data_register_i[ADDR_MSB:ADDR_LSB];
      else if (ctrl_i.addr_inc) addr_q <= addr_q + 32'd1;  // SPRs are word addressed
      if (ctrl_i.op_ld) op_q <= data_register_i[OP_MSB:OP_LSB];
      if (ctrl_i.bit_clr) bit_q <= '0;
      else if (ctrl_i.bit_en) bit_q <= bit_q + 6'd1;
      if (ctrl_i.word_ld) word_q <= data_register_i[CNT_LSB +: COUNT_W];
      else if (ctrl_i.word_dec) word_q <= word_q - COUNT_W'(1);
    end
  end

  assign addr_o                 = addr_q;
  assign rd_o                   = op_q[OP_RD_BIT];
  assign flags_o.word_zero      = (word_q == '0);
  assign flags_o.word_next_zero = (word_q == COUNT_W'(1));  // Last word after this one
  assign flags_o.bit_max        = (bit_q == 6'd31);
  assign flags_o.bit_32         = (bit_q == 6'd32);

  // Register select and its read mux
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) regsel_q <= '0;
    else if (ctrl_i.regsel_ld) regsel_q <= regsel_in;
  end

  always_comb begin
    case (regsel_q)
      REGSEL_W'(INTREG_STATUS): intreg_data = {30'h0, status_i};
      default:                  intreg_data = 32'h0;
    endcase
  end

  // Write goes to the register named in the same command
  assign status_we_o = ctrl_i.intreg_we & (regsel_in == REGSEL_W'(INTREG_STATUS));

  ////////////////////
  // Output shift register, bus data only once the bus unit is ready
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_q <= '0;
    end else if (ctrl_i.out_ld && (ctrl_i.out_src || biu_ready_i)) begin
      out_q <= ctrl_i.out_src ? intreg_data : biu_rdata_i;
    end else if (ctrl_i.out_shift) begin
      out_q <= {1'b0, out_q[31:1]};  // LSB first
    end
  end

  assign shift_lsb_o = out_q[0];

  always_comb begin
    case (ctrl_i.tdo_sel)
      TDO_READY: tdo_o = biu_ready_i;
      TDO_DATA:  tdo_o = out_q[0];
      TDO_MATCH: tdo_o = crc_match_i;
      default:   tdo_o = crc_serial_i;
    endcase
  end

endmodule

/* src/dbg_crc32.sv */
// Bit-serial reflected CRC-32, starts at all ones, no final inversion
module dbg_crc32 import dbg_pkg::*; (
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        tdi_i,
  input  logic        read_bit_i,   // Read data as it leaves on TDO
  input  crc_ctrl_t   ctrl_i,
  input  logic [31:0] check_i,      // CRC shifted in by the host
  output logic        match_o,
  output logic        serial_o
);

  logic [31:0] crc_q;
  logic        din;
  logic        fb;

  assign din = ctrl_i.in_sel ? tdi_i : read_bit_i;
  assign fb  = crc_q[0] ^ din;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else if (ctrl_i.clr) begin
      crc_q <= '1;
    end else if (ctrl_i.en) begin
      crc_q <= {1'b0, crc_q[31:1]} ^ (fb ? CRC_POLY : 32'h0);
    end else if (ctrl_i.shift) begin
      crc_q <= {1'b0, crc_q[31:1]};  // Register doubles as the output shifter
    end
  end

  assign serial_o = crc_q[0];
  assign match_o  = (crc_q == check_i);

endmodule

/* src/dbg_spr_biu.sv */
// SPR bus unit on tck, one transfer per strobe
// A new strobe must not arrive before ready, the FSM keeps to that
module dbg_spr_biu import dbg_pkg::*; (
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        strobe_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic        rd_i,
  output logic        ready_o,
  output logic [31:0] rdata_o,
  output spr_req_t    spr_o,
  input  logic [31:0] cpu_data_i,
  input  logic        cpu_ack_i
);

  logic        stb_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic        we_q;
  logic [31:0] rdata_q;

  ////////////////////
  // Strobe handshake
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stb_q <= 1'b0;
    end else if (strobe_i) begin
      stb_q <= 1'b1;
    end else if (cpu_ack_i) begin
      stb_q <= 1'b0;  // First ack ends the transfer
    end
  end

  // Request and read data payload
  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      we_q    <= ~rd_i;
    end
    if (stb_q && cpu_ack_i && !we_q) begin
      rdata_q <= cpu_data_i;
    end
  end

  assign ready_o     = ~stb_q;  // Low from the cycle after strobe until after ack
  assign rdata_o     = rdata_q;
  assign spr_o.addr  = addr_q;
  assign spr_o.wdata = wdata_q;
  assign spr_o.stb   = stb_q;
  assign spr_o.we    = we_q;

endmodule

/* src/dbg_status_reg.sv */
// CPU stall and reset control bits, breakpoint sets stall
module dbg_status_reg (
  input  logic       tck_i,
  input  logic       rst_i,
  input  logic       we_i,
  input  logic [1:0] data_i,    // Bit 0 stall, bit 1 reset
  input  logic       bp_i,
  output logic [1:0] status_o,
  output logic       cpu_stall_o,
  output logic       cpu_rst_o
);

  logic [1:0] status_q;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      status_q <= 2'b00;
    end else begin
      if (we_i) status_q <= data_i;
      if (bp_i) status_q[0] <= 1'b1;  // Breakpoint wins over a write of stall
    end
  end

  assign status_o    = status_q;
  assign cpu_stall_o = status_q[0];
  assign cpu_rst_o   = status_q[1];

endmodule

/* src/dbg_or1k_top.sv */
// OR1K debug module top, every unit clocked by tck
// Data register fields follow the 53-bit layout in the package
module dbg_or1k_top import dbg_pkg::*; #(
  parameter int COUNT_W = 16
) (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic            tdi_i,
  input  tap_ctrl_t       tap_i,
  input  logic [DR_W-1:0] data_register_i,
  output logic            module_tdo_o,
  output logic            top_inhibit_o,
  output spr_req_t        spr_o,
  input  logic [31:0]     cpu_data_i,
  input  logic            cpu_ack_i,
  input  logic            cpu_bp_i,
  output logic            cpu_stall_o,
  output logic            cpu_rst_o
);

  dbg_ctrl_t   ctrl;
  dbg_flags_t  flags;
  crc_ctrl_t   crc_ctrl;
  logic        biu_strobe, biu_ready, rd;
  logic [31:0] addr, rdata;
  logic [1:0]  status;
  logic        status_we, crc_match, crc_serial, shift_lsb;

  dbg_cmd_fsm fsm0 (
    .tck_i, .rst_i, .tap_i,
    .opcode_i     (dbg_cmd_e'(data_register_i[OP_MSB:OP_LSB])),
    .cmd_for_me_i (~data_register_i[DR_TOP_BIT]),
    .start_bit_i  (data_register_i[DR_TOP_BIT]),
    .flags_i      (flags),
    .biu_ready_i  (biu_ready),
    .ctrl_o       (ctrl),
    .crc_o        (crc_ctrl),
    .biu_strobe_o (biu_strobe),
    .top_inhibit_o
  );

  dbg_burst_datapath #(.COUNT_W(COUNT_W)) dp0 (
    .tck_i, .rst_i, .data_register_i,
    .ctrl_i       (ctrl),
    .biu_rdata_i  (rdata),
    .status_i     (status),
    .biu_ready_i  (biu_ready),
    .crc_match_i  (crc_match),
    .crc_serial_i (crc_serial),
    .flags_o      (flags),
    .addr_o       (addr),
    .rd_o         (rd),
    .status_we_o  (status_we),
    .shift_lsb_o  (shift_lsb),
    .tdo_o        (module_tdo_o)
  );

  // CRC sees the host CRC once all 32 bits sit at the top of the DR
  dbg_crc32 crc0 (
    .tck_i, .rst_i, .tdi_i,
    .read_bit_i (shift_lsb),
    .ctrl_i     (crc_ctrl),
    .check_i    (data_register_i[DR_TOP_BIT -: 32]),
    .match_o    (crc_match),
    .serial_o   (crc_serial)
  );

  // Write word is tdi plus 31 bits already in the DR
  dbg_spr_biu biu0 (
    .tck_i, .rst_i,
    .strobe_i (biu_strobe),
    .addr_i   (addr),
    .wdata_i  ({tdi_i, data_register_i[DR_TOP_BIT -: 31]}),
    .rd_i     (rd),
    .ready_o  (biu_ready),
    .rdata_o  (rdata),
    .spr_o, .cpu_data_i, .cpu_ack_i
  );

  dbg_status_reg stat0 (
    .tck_i, .rst_i,
    .we_i     (status_we),
    .data_i   (data_register_i[STAT_MSB -: 2]),
    .bp_i     (cpu_bp_i),
    .status_o (status),
    .cpu_stall_o, .cpu_rst_o
  );

endmodule

/* tests/tb_dbg_or1k.sv */
// Testbench for the OR1K debug module with TAP shift register and CPU bus models
// Inputs change 5 units after the rising edge and TDO is sampled on the falling edge
module tb_dbg_or1k;
  import dbg_pkg::*;

  localparam int TIMEOUT = 6000;  // Six tests of well under 500 cycles each
  localparam logic [31:0] SEED = 32'hfeae_900e;
  localparam tap_ctrl_t T_IDLE = 4'b0000;
  localparam tap_ctrl_t T_CAP  = 4'b1001;  // capture, shift, update, sel
  localparam tap_ctrl_t T_SHFT = 4'b0101;
  localparam tap_ctrl_t T_UPD  = 4'b0011;

  logic            tck_i = 1'b0;
  logic            rst_i;
  logic            tdi_i;
  tap_ctrl_t       tap_i;
  logic [DR_W-1:0] data_register_i;
  logic            module_tdo_o, top_inhibit_o;
  spr_req_t        spr;
  logic [31:0]     cpu_data_i;
  logic            cpu_ack_i, cpu_bp_i;
  logic            cpu_stall_o, cpu_rst_o;

  int          errs = 0;
  int          tests = 0;
  int          cycles = 0;
  int          ack_wait = 0;
  logic        chk_inhibit = 1'b0;   // Read burst in progress
  logic        chk_no_stb = 1'b0;    // Bus must stay quiet
  logic [31:0] wr_addr[$];
  logic [31:0] wr_data[$];
  logic [31:0] wwords[4];

  dbg_or1k_top #(.COUNT_W(16)) dut0 (
    .tck_i, .rst_i, .tdi_i, .tap_i, .data_register_i, .module_tdo_o, .top_inhibit_o,
    .spr_o (spr), .cpu_data_i, .cpu_ack_i, .cpu_bp_i, .cpu_stall_o, .cpu_rst_o
  );

  always #50 tck_i = ~tck_i;

  always @(posedge tck_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////
  // CPU bus model acking after 0 to 3 cycles
  always @(posedge tck_i) begin
    #5;
    cpu_ack_i = 1'b0;
    if (!rst_i && spr.stb) begin
      if (ack_wait == 0) begin
        cpu_ack_i  = 1'b1;
        cpu_data_i = spr.addr ^ 32'hA5A5_0000;
        if (spr.we) begin
          wr_addr.push_back(spr.addr);
          wr_data.push_back(spr.wdata);
        end
        ack_wait = $urandom % 4;  // Delay for the next transfer
      end else begin
        ack_wait--;
      end
    end
  end

  assert property (@(posedge tck_i) chk_inhibit |-> top_inhibit_o)
    else begin
      errs++;
      $display("Error at %0t: top_inhibit_o got 0 expected 1", $time);
    end

  assert property (@(posedge tck_i) chk_no_stb |-> !spr.stb && !top_inhibit_o)
    else begin
      errs++;
      $display("Error at %0t: bus strobe or inhibit seen after the burst was aborted", $time);
    end

  ////////////////////
  // Helpers
  function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic b);
    logic fb;
    fb = crc[0] ^ b;
    return (crc >> 1) ^ (fb ? 32'hEDB8_8320 : 32'h0);
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      errs++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests++;
    if (errs == errs_at_start) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, errs - errs_at_start);
  endtask

  // One TCK cycle with the DR shifting at the edge like the TAP
  task automatic clock_cycle(input tap_ctrl_t t, input logic b, output logic tdo);
    tap_i = t;
    tdi_i = b;
    @(negedge tck_i);
    tdo = module_tdo_o;
    @(posedge tck_i);
    #5;
    if (t.sel && t.shift) data_register_i = {b, data_register_i[DR_W-1:1]};
    tap_i = T_IDLE;
  endtask

  task automatic send_cmd(input logic [3:0] op, input logic [31:0] addr, input logic [15:0] n);
    logic t;
    data_register_i = {1'b0, op, addr, n};
    clock_cycle(T_UPD, 1'b0, t);
  endtask

  task automatic write_status(input logic [1:0] v);
    logic [31:0] a;
    a = {1'b0, v, 29'h0};  // Select 0 at bit 47 and data at 46 and 45
    send_cmd(CMD_IREG_WR, a, 16'h0);
  endtask

  task automatic read_status(output logic [1:0] v);
    logic t;
    send_cmd(CMD_IREG_SEL, 32'h0, 16'h0);
    clock_cycle(T_CAP, 1'b0, t);
    clock_cycle(T_SHFT, 1'b0, v[0]);
    clock_cycle(T_SHFT, 1'b0, v[1]);
  endtask

  task automatic burst_write(input logic [31:0] addr, input bit flip, output logic match);
    logic        t;
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    send_cmd(CMD_BWRITE32, addr, 16'd4);
    clock_cycle(T_CAP, 1'b0, t);
    clock_cycle(T_SHFT, 1'b1, t);  // Start bit
    for (int w = 0; w < 4; w++) begin
      for (int i = 0; i < 32; i++) begin
        crc = crc_step(crc, wwords[w][i]);
        clock_cycle(T_SHFT, wwords[w][i], t);
      end
    end
    if (flip) crc[5] = ~crc[5];
    for (int i = 0; i < 32; i++) clock_cycle(T_SHFT, crc[i], t);
    clock_cycle(T_SHFT, 1'b0, match);
    clock_cycle(T_UPD, 1'b0, t);
    clock_cycle(T_IDLE, 1'b0, t);
  endtask

  ////////////////////
  // Stimulus
  initial begin
    int          e0;
    int          n;
    logic        t;
    logic        match;
    logic [1:0]  st;
    logic [31:0] word, crc, rcrc;
    logic [31:0] exp_word;

    void'($urandom(SEED));
    rst_i = 1'b1;
    tdi_i = 1'b0;
    tap_i = T_IDLE;
    data_register_i = '0;
    cpu_data_i = '0;
    cpu_ack_i = 1'b0;
    cpu_bp_i = 1'b0;
    repeat (8) @(posedge tck_i);
    #5;
    rst_i = 1'b0;

    e0 = errs;
    expect_eq("spr_o.stb", spr.stb, 0);
    expect_eq("top_inhibit_o", top_inhibit_o, 0);
    expect_eq("cpu_stall_o", cpu_stall_o, 0);
    expect_eq("cpu_rst_o", cpu_rst_o, 0);
    report_test("reset", e0);

    e0 = errs;
    write_status(2'b11);
    expect_eq("cpu_stall_o", cpu_stall_o, 1);
    expect_eq("cpu_rst_o", cpu_rst_o, 1);
    read_status(st);
    expect_eq("status", st, 2'b11);
    write_status(2'b00);
    read_status(st);
    expect_eq("status", st, 2'b00);
    expect_eq("cpu_rst_o", cpu_rst_o, 0);
    report_test("status register", e0);

    e0 = errs;
    cpu_bp_i = 1'b1;
    clock_cycle(T_IDLE, 1'b0, t);
    cpu_bp_i = 1'b0;
    expect_eq("cpu_stall_o", cpu_stall_o, 1);
    expect_eq("cpu_rst_o", cpu_rst_o, 0);
    read_status(st);
    expect_eq("status", st, 2'b01);
    write_status(2'b00);
    report_test("breakpoint", e0);

    e0 = errs;
    foreach (wwords[i]) wwords[i] = $urandom;
    wr_addr.delete();
    wr_data.delete();
    burst_write(32'd40, 1'b0, match);
    expect_eq("match bit", match, 1);
    expect_eq("write count", wr_addr.size(), 4);
    n = (wr_addr.size() < 4) ? wr_addr.size() : 4;
    for (int i = 0; i < n; i++) begin
      expect_eq("spr_o.addr", wr_addr[i], 32'd40 + i);
      expect_eq("spr_o.wdata", wr_data[i], wwords[i]);
    end
    burst_write(32'd40, 1'b1, match);
    expect_eq("match bit", match, 0);
    report_test("burst write", e0);

    e0 = errs;
    crc = 32'hFFFF_FFFF;
    send_cmd(CMD_BREAD32, 32'd100, 16'd3);
    clock_cycle(T_IDLE, 1'b0, t);
    clock_cycle(T_CAP, 1'b0, t);
    chk_inhibit = 1'b1;
    n = 0;
    t = 1'b0;
    while (!t && n < 20) begin  // Status zeros until the ready bit
      clock_cycle(T_SHFT, 1'b0, t);
      n++;
    end
    if (!t) begin
      errs++;
      $display("Read burst at %0t never showed the ready bit", $time);
    end
    for (int w = 0; w < 3; w++) begin
      exp_word = (32'd100 + w) ^ 32'hA5A5_0000;
      for (int i = 0; i < 32; i++) clock_cycle(T_SHFT, 1'b0, word[i]);
      expect_eq("read word", word, exp_word);
      for (int i = 0; i < 32; i++) crc = crc_step(crc, exp_word[i]);
    end
    for (int i = 0; i < 32; i++) clock_cycle(T_SHFT, 1'b0, rcrc[i]);
    expect_eq("read crc", rcrc, crc);
    chk_inhibit = 1'b0;
    clock_cycle(T_UPD, 1'b0, t);
    report_test("burst read", e0);

    e0 = errs;
    wr_addr.delete();
    send_cmd(CMD_BWRITE32, 32'd200, 16'd4);
    clock_cycle(T_CAP, 1'b0, t);
    clock_cycle(T_SHFT, 1'b1, t);
    for (int i = 0; i < 40; i++) clock_cycle(T_SHFT, 1'($urandom), t);
    clock_cycle(T_UPD, 1'b0, t);  // Abort mid word 1
    chk_no_stb = 1'b1;
    repeat (45) clock_cycle(T_IDLE, 1'b0, t);
    chk_no_stb = 1'b0;
    expect_eq("write count", wr_addr.size(), 1);
    report_test("burst abort", e0);

    $display("Tests run %0d, checks failed %0d", tests, errs);
    if (errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* src.f */
src/dbg_pkg.sv
src/dbg_cmd_fsm.sv
src/dbg_burst_datapath.sv
src/dbg_crc32.sv
src/dbg_spr_biu.sv
src/dbg_status_reg.sv
src/dbg_or1k_top.sv
tests/tb_dbg_or1k.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, result taken from the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dbg_or1k -f src.f -o sim_dbg \
  && ./obj_dir/sim_dbg > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log && exit 0 || exit 1
